/* nts_engine.f */
+incdir+logic
logic/nts_engine_pkg.sv
logic/nts_event_counter.sv
logic/nts_debug_stats.sv
logic/nts_engine_id_regs.sv
logic/nts_api_decode.sv
logic/nts_engine.sv
dv/nts_engine_chk.sv
dv/nts_engine_tb.sv

/* dv/nts_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_settings.svh"

module nts_engine_tb;

  import nts_engine_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_RAND       = 200;   // Random event cycles
  localparam int K_TICK       = 25;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_RAND + K_TICK + 250;
  localparam int WATCHDOG_NS  = TOTAL_CYCLES * 40 + 2000;

  logic         i_clk;
  logic         i_areset;
  logic         i_api_cs;
  logic         i_api_we;
  api_addr_t    i_api_address;
  api_data_t    i_api_write_data;
  api_data_t    o_api_read_data;
  stat_events_t i_events;

  stat_count_t  model [6];             // Expected count per event
  local_addr_t  cnt_addr [6];          // Upper-half address per event
  logic [31:0]  rng_state;
  int           n_checks;
  int           n_errors;
  int           n_tests;
  int           n_assert_fails;

  nts_engine i_dut (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .i_api_write_data (i_api_write_data),
    .o_api_read_data  (o_api_read_data),
    .i_events         (i_events)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // Helpers --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic api_addr_t eng_addr(input local_addr_t a);
    return {`NTS_BLOCK_ENGINE, a};
  endfunction

  function automatic api_addr_t dbg_addr(input local_addr_t a);
    return {`NTS_BLOCK_DEBUG, a};
  endfunction

  // Bit i of ev_bits is event i, same order as cnt_addr
  task automatic bus_cycle(input logic cs, input logic we, input api_addr_t addr,
                           input api_data_t wdata, input logic [5:0] ev_bits,
                           output api_data_t rdata);
    @(posedge i_clk);
    #2;
    i_api_cs         = cs;
    i_api_we         = we;
    i_api_address    = addr;
    i_api_write_data = wdata;
    i_events.processed  = ev_bits[0];
    i_events.bad_cookie = ev_bits[1];
    i_events.bad_auth   = ev_bits[2];
    i_events.bad_keyid  = ev_bits[3];
    i_events.err_crypto = ev_bits[4];
    i_events.err_txbuf  = ev_bits[5];
    for (int i = 0; i < 6; i++)
      model[i] = model[i] + ev_bits[i];   // Counts at the edge ending this cycle
    @(negedge i_clk);
    rdata = o_api_read_data;
  endtask

  task automatic read_word(input api_addr_t addr, output api_data_t data);
    bus_cycle(1'b1, 1'b0, addr, '0, 6'b0, data);
  endtask

  task automatic idle_cycle();
    api_data_t unused;
    bus_cycle(1'b0, 1'b0, '0, '0, 6'b0, unused);
  endtask

  task automatic read_counter(input int idx, output stat_count_t value);
    api_data_t hi;
    api_data_t lo;
    read_word(dbg_addr(cnt_addr[idx]), hi);
    read_word(dbg_addr(local_addr_t'(cnt_addr[idx] + 8'd1)), lo);
    value = {hi, lo};
  endtask

  // Compare tasks --------------------
  task automatic check_data(input string what, input api_data_t got, input api_data_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input stat_count_t got,
                             input stat_count_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("** Error at %0t ns: %s read 0x%016h, expected 0x%016h",
               $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    n_tests++;
    $display("Test %0s: %0s", name, (n_errors == errors_before) ? "ok" : "mismatches");
  endtask

  task automatic check_identity();
    api_data_t d;
    read_word(eng_addr(`NTS_ADDR_NAME0), d);
    check_data("name0", d, 32'h4e54535f);               // "NTS_"
    read_word(eng_addr(`NTS_ADDR_NAME1), d);
    check_data("name1", d, 32'h454e474e);               // "ENGN"
    read_word(eng_addr(`NTS_ADDR_VERSION), d);
    check_data("version", d, 32'h302e3032);             // "0.02"
    read_word(eng_addr(`NTS_ADDR_CTRL), d);
    check_data("ctrl", d, 32'd1);
  endtask

  // Tests --------------------
  task automatic test_identity();
    int        e0;
    api_data_t d;
    e0 = n_errors;
    check_identity();
    read_word(eng_addr(8'h03), d);
    check_data("engine addr 3", d, '0);
    read_word({4'h5, 8'h00}, d);
    check_data("unmapped block", d, '0);
    idle_cycle();
    report_test("identity", e0);
  endtask

  task automatic test_reset_state();
    int          e0;
    api_data_t   d;
    stat_count_t c;
    e0 = n_errors;
    bus_cycle(1'b0, 1'b0, dbg_addr(`NTS_DBG_NAME), '0, 6'b0, d);
    check_data("deselected read", d, '0);
    for (int i = 0; i < 6; i++)
    begin
      read_counter(i, c);
      check_count($sformatf("counter %0d after reset", i), c, '0);
    end
    read_word(dbg_addr(`NTS_DBG_NAME), d);
    check_data("debug name", d, 32'h44425547);          // "DBUG"
    idle_cycle();
    report_test("reset_state", e0);
  endtask

  task automatic test_random_events();
    int          e0;
    api_data_t   unused;
    stat_count_t c;
    e0 = n_errors;
    for (int n = 0; n < N_RAND; n++)
    begin
      rng_state = xorshift32(rng_state);
      bus_cycle(1'b0, 1'b0, '0, '0, rng_state[5:0], unused);
    end
    idle_cycle();
    for (int i = 0; i < 6; i++)
    begin
      read_counter(i, c);
      check_count($sformatf("counter %0d", i), c, model[i]);
    end
    report_test("random_events", e0);
  endtask

  task automatic test_snapshot();
    int          e0;
    api_data_t   hi;
    api_data_t   lo;
    api_data_t   unused;
    stat_count_t expected;
    stat_count_t c;
    e0 = n_errors;
    for (int i = 0; i < 6; i++)
    begin
      expected = model[i];   // Value seen during the upper-half read
      bus_cycle(1'b1, 1'b0, dbg_addr(cnt_addr[i]), '0, 6'b1 << i, hi);
      repeat (4) bus_cycle(1'b0, 1'b0, '0, '0, 6'b1 << i, unused);
      read_word(dbg_addr(local_addr_t'(cnt_addr[i] + 8'd1)), lo);
      check_count($sformatf("counter %0d snapshot", i), {hi, lo}, expected);
      read_counter(i, c);
      check_count($sformatf("counter %0d after pulses", i), c, model[i]);
    end
    idle_cycle();
    report_test("snapshot", e0);
  endtask

  task automatic test_tick_and_writes();
    int          e0;
    api_data_t   t0;
    api_data_t   t1;
    api_data_t   unused;
    stat_count_t c;
    e0 = n_errors;
    read_word(dbg_addr(`NTS_DBG_SYSTICK), t0);
    repeat (K_TICK - 1) idle_cycle();
    read_word(dbg_addr(`NTS_DBG_SYSTICK), t1);
    check_data("systick delta", t1 - t0, api_data_t'(K_TICK));
    // Writes over both blocks, then everything must read as before
    for (int a = 0; a < 16; a++)
    begin
      rng_state = xorshift32(rng_state);
      bus_cycle(1'b1, 1'b1, eng_addr(local_addr_t'(a)), rng_state, 6'b0, unused);
    end
    for (int a = 0; a < 36; a++)
    begin
      rng_state = xorshift32(rng_state);
      bus_cycle(1'b1, 1'b1, dbg_addr(local_addr_t'(a)), rng_state, 6'b0, unused);
    end
    check_identity();
    read_word(dbg_addr(`NTS_DBG_NAME), t0);
    check_data("debug name after writes", t0, 32'h44425547);
    for (int i = 0; i < 6; i++)
    begin
      read_counter(i, c);
      check_count($sformatf("counter %0d after writes", i), c, model[i]);
    end
    idle_cycle();
    report_test("tick_and_writes", e0);
  endtask

  // Watchdog --------------------
  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    i_areset         = 1'b1;
    i_api_cs         = 1'b0;
    i_api_we         = 1'b0;
    i_api_address    = '0;
    i_api_write_data = '0;
    i_events         = '0;
    rng_state        = 32'd53638;
    n_checks         = 0;
    n_errors         = 0;
    n_tests          = 0;
    n_assert_fails   = 0;
    cnt_addr = '{`NTS_DBG_PROCESSED, `NTS_DBG_BAD_COOKIE, `NTS_DBG_BAD_AUTH,
                 `NTS_DBG_BAD_KEYID, `NTS_DBG_ERR_CRYPTO, `NTS_DBG_ERR_TXBUF};
    for (int i = 0; i < 6; i++)
      model[i] = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #2;
    i_areset = 1'b0;

    test_identity();
    test_reset_state();
    test_random_events();
    test_snapshot();
    test_tick_and_writes();

    n_assert_fails = i_dut.u_debug.i_chk.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             n_tests, n_checks, n_errors, n_assert_fails);
    if (n_errors == 0 && n_assert_fails == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/nts_engine_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module nts_engine_chk (
  input wire                            i_clk,
  input wire                            i_areset,
  input wire                            i_cs,
  input wire nts_engine_pkg::api_data_t i_rdata,
  input wire nts_engine_pkg::systick_t  i_systick,
  input wire [5:0]                      i_snap,              // Capture strobes
  input wire nts_engine_pkg::api_data_t i_snap_lo [0:5]
);

  import nts_engine_pkg::*;

  localparam int N_CNT = 6;

  int fail_count = 0;   // Failed assertion evaluations

  // Tick --------------------
  // First edge after reset release still sees the reset value
  a_tick_step: assert property (@(posedge i_clk) disable iff (i_areset)
    !$past(i_areset) |-> i_systick == systick_t'($past(i_systick) + 1'b1))
    else
    begin
      $error("system tick did not advance by one");
      fail_count++;
    end

  // Snapshots --------------------
  for (genvar g = 0; g < N_CNT; g++)
  begin : g_snap
    a_snap_hold: assert property (@(posedge i_clk) disable iff (i_areset)
      (i_snap_lo[g] != $past(i_snap_lo[g])) |-> $past(i_snap[g]))
      else
      begin
        $error("snapshot %0d changed without its strobe", g);
        fail_count++;
      end
  end

  // Idle read data
  a_idle_zero: assert property (@(posedge i_clk) !i_cs |-> i_rdata == '0)
    else
    begin
      $error("debug read data not zero while deselected");
      fail_count++;
    end

endmodule

bind nts_debug_stats nts_engine_chk i_chk (
  .i_clk     (i_clk),
  .i_areset  (i_areset),
  .i_cs      (i_cs),
  .i_rdata   (o_rdata),
  .i_systick (systick_reg),
  .i_snap    (snap),
  .i_snap_lo (snap_lo)
);

`default_nettype wire

/* logic/nts_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_settings.svh"

module nts_engine (
  input  wire                          i_clk,
  input  wire                          i_areset,

  // Host API
  input  wire                          i_api_cs,
  input  wire                          i_api_we,
  input  wire nts_engine_pkg::api_addr_t i_api_address,
  input  wire nts_engine_pkg::api_data_t i_api_write_data,
  output nts_engine_pkg::api_data_t    o_api_read_data,

  // Statistics strobes
  input  wire nts_engine_pkg::stat_events_t i_events
);

  import nts_engine_pkg::*;

  api_req_t  req;        // Shared by both blocks
  logic      engine_cs;
  logic      debug_cs;
  api_data_t engine_rdata;
  api_data_t debug_rdata;

  // Address decode --------------------
  nts_api_decode u_decode (
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .i_api_write_data (i_api_write_data),
    .o_req            (req),
    .o_engine_cs      (engine_cs),
    .o_debug_cs       (debug_cs),
    .i_engine_rdata   (engine_rdata),
    .i_debug_rdata    (debug_rdata),
    .o_api_read_data  (o_api_read_data)
  );

  // Identity block --------------------
  nts_engine_id_regs u_id_regs (
    .i_cs    (engine_cs),
    .i_req   (req),
    .o_rdata (engine_rdata)
  );

  // Statistics block --------------------
  nts_debug_stats u_debug (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_cs     (debug_cs),
    .i_req    (req),
    .i_events (i_events),
    .o_rdata  (debug_rdata)
  );

endmodule

`default_nettype wire

/* logic/nts_api_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_settings.svh"

module nts_api_decode (
  // External side
  input  wire                            i_api_cs,
  input  wire                            i_api_we,
  input  wire nts_engine_pkg::api_addr_t i_api_address,
  input  wire nts_engine_pkg::api_data_t i_api_write_data,

  // Block side
  output nts_engine_pkg::api_req_t       o_req,
  output logic                           o_engine_cs,
  output logic                           o_debug_cs,
  input  wire nts_engine_pkg::api_data_t i_engine_rdata,
  input  wire nts_engine_pkg::api_data_t i_debug_rdata,

  output nts_engine_pkg::api_data_t      o_api_read_data
);

  import nts_engine_pkg::*;

  block_sel_t  block_sel;
  local_addr_t local_addr;

  // Split address --------------------
  assign block_sel  = i_api_address[`NTS_API_ADDR_W-1 -: `NTS_BLOCK_W];
  assign local_addr = i_api_address[`NTS_LOCAL_ADDR_W-1:0];

  assign o_req = '{
    we:    i_api_we,
    addr:  local_addr,
    wdata: i_api_write_data
  };

  // One select per block, others fall through to zero
  assign o_engine_cs = i_api_cs && (block_sel == `NTS_BLOCK_ENGINE);
  assign o_debug_cs  = i_api_cs && (block_sel == `NTS_BLOCK_DEBUG);

  // Blocks drive zero when not selected
  assign o_api_read_data = i_engine_rdata | i_debug_rdata;

endmodule

`default_nettype wire

/* logic/nts_engine_id_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_settings.svh"

module nts_engine_id_regs (
  input  wire                            i_cs,
  input  wire nts_engine_pkg::api_req_t  i_req,
  output nts_engine_pkg::api_data_t      o_rdata
);

  import nts_engine_pkg::*;

  api_data_t id_word;   // Value at the current address
  logic      rd;

  assign rd = i_cs && !i_req.we;   // Writes land nowhere

  // Identity map --------------------
  always_comb
  begin
    case (i_req.addr)
      `NTS_ADDR_NAME0:   id_word = `NTS_ENGINE_NAME0;
      `NTS_ADDR_NAME1:   id_word = `NTS_ENGINE_NAME1;
      `NTS_ADDR_VERSION: id_word = `NTS_ENGINE_VERSION;
      `NTS_ADDR_CTRL:    id_word = `NTS_CTRL_VALUE;
      default:           id_word = '0;
    endcase
  end

  // Zero unless read, keeps the decoder OR clean
  assign o_rdata = rd ? id_word : '0;

endmodule

`default_nettype wire

/* logic/nts_debug_stats.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_settings.svh"

module nts_debug_stats (
  input  wire                               i_clk,
  input  wire                               i_areset,
  input  wire                               i_cs,
  input  wire nts_engine_pkg::api_req_t     i_req,
  input  wire nts_engine_pkg::stat_events_t i_events,
  output nts_engine_pkg::api_data_t         o_rdata
);

  import nts_engine_pkg::*;

  localparam int N_CNT = 6;

  // Upper-half address of each counter, lower half sits one above
  localparam local_addr_t CNT_BASE [N_CNT] = '{
    `NTS_DBG_PROCESSED,
    `NTS_DBG_BAD_COOKIE,
    `NTS_DBG_BAD_AUTH,
    `NTS_DBG_BAD_KEYID,
    `NTS_DBG_ERR_CRYPTO,
    `NTS_DBG_ERR_TXBUF
  };

  logic [N_CNT-1:0] inc;                // Index order follows CNT_BASE
  logic [N_CNT-1:0] snap;               // Lower-half capture strobes
  stat_count_t      count   [N_CNT];
  api_data_t        snap_lo [N_CNT];
  systick_t         systick_reg;
  logic             rd;

  assign inc = {
    i_events.err_txbuf,
    i_events.err_crypto,
    i_events.bad_keyid,
    i_events.bad_auth,
    i_events.bad_cookie,
    i_events.processed
  };

  // Counters --------------------
  for (genvar g = 0; g < N_CNT; g++)
  begin : g_cnt
    nts_event_counter u_cnt (
      .i_clk     (i_clk),
      .i_areset  (i_areset),
      .i_inc     (inc[g]),
      .i_snap    (snap[g]),
      .o_count   (count[g]),
      .o_snap_lo (snap_lo[g])
    );
  end

  // System tick --------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      systick_reg <= systick_t'(1);   // Starts at one
    end
    else
    begin
      systick_reg <= systick_reg + 1'b1;
    end
  end

  assign rd = i_cs && !i_req.we;

  // Read map --------------------
  // A read of the upper half also arms the capture of the lower half,
  // so the following read of base+1 returns a matching word
  always_comb
  begin
    o_rdata = '0;
    snap    = '0;
    if (rd)
    begin
      case (i_req.addr)
        `NTS_DBG_NAME:    o_rdata = `NTS_DEBUG_NAME;
        `NTS_DBG_SYSTICK: o_rdata = systick_reg;
        default:          o_rdata = '0;
      endcase

      for (int i = 0; i < N_CNT; i++)
      begin
        if (i_req.addr == CNT_BASE[i])
        begin
          o_rdata = count[i][`NTS_CNT_W-1:`NTS_API_DATA_W];
          snap[i] = 1'b1;
        end
        if (i_req.addr == local_addr_t'(CNT_BASE[i] + 1'b1))
        begin
          o_rdata = snap_lo[i];   // Captured value, not live count
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/nts_event_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "nts_engine_settings.svh"

module nts_event_counter (
  input  wire                 i_clk,
  input  wire                 i_areset,
  input  wire                 i_inc,     // One event this cycle
  input  wire                 i_snap,    // Upper half being read
  output nts_engine_pkg::stat_count_t o_count,
  output nts_engine_pkg::api_data_t   o_snap_lo
);

  import nts_engine_pkg::*;

  stat_count_t count_reg;
  api_data_t   snap_reg;

  // Count and capture --------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count_reg <= '0;
      snap_reg  <= '0;
    end
    else
    begin
      if (i_inc)
      begin
        count_reg <= count_reg + 1'b1;
      end

      // Takes the pre-increment value, same count the host saw
      if (i_snap)
      begin
        snap_reg <= count_reg[`NTS_API_DATA_W-1:0];
      end
    end
  end

  assign o_count   = count_reg;
  assign o_snap_lo = snap_reg;

endmodule

`default_nettype wire

/* logic/nts_engine_pkg.sv */
`default_nettype none

`include "nts_engine_settings.svh"

package nts_engine_pkg;

  // Plain vectors --------------------
  typedef logic [`NTS_API_ADDR_W-1:0]   api_addr_t;
  typedef logic [`NTS_LOCAL_ADDR_W-1:0] local_addr_t;
  typedef logic [`NTS_BLOCK_W-1:0]      block_sel_t;
  typedef logic [`NTS_API_DATA_W-1:0]   api_data_t;
  typedef logic [`NTS_CNT_W-1:0]        stat_count_t;
  typedef logic [`NTS_SYSTICK_W-1:0]    systick_t;

  // Request seen by every block behind the decoder
  typedef struct packed {
    logic        we;
    local_addr_t addr;   // Block select already stripped
    api_data_t   wdata;
  } api_req_t;

  // One strobe per statistics event
  typedef struct packed {
    logic processed;
    logic bad_cookie;
    logic bad_auth;
    logic bad_keyid;
    logic err_crypto;
    logic err_txbuf;
  } stat_events_t;

endpackage

`default_nettype wire

/* logic/nts_engine_settings.svh */
`ifndef NTS_ENGINE_SETTINGS_SVH
`define NTS_ENGINE_SETTINGS_SVH

// Widths --------------------
`define NTS_API_ADDR_W    12
`define NTS_API_DATA_W    32
`define NTS_LOCAL_ADDR_W  8
`define NTS_BLOCK_W       4   // Top address bits
`define NTS_CNT_W         64
`define NTS_SYSTICK_W     32

// Block selects --------------------
`define NTS_BLOCK_ENGINE  4'h0
`define NTS_BLOCK_DEBUG   4'h1

// Identity constants, ASCII
`define NTS_ENGINE_NAME0   32'h4e_54_53_5f  // "NTS_"
`define NTS_ENGINE_NAME1   32'h45_4e_47_4e  // "ENGN"
`define NTS_ENGINE_VERSION 32'h30_2e_30_32  // "0.02"
`define NTS_DEBUG_NAME     32'h44_42_55_47  // "DBUG"
`define NTS_CTRL_VALUE     32'h0000_0001

// Engine register map --------------------
`define NTS_ADDR_NAME0     8'h00
`define NTS_ADDR_NAME1     8'h01
`define NTS_ADDR_VERSION   8'h02
`define NTS_ADDR_CTRL      8'h08

// Debug register map, counters take two words
`define NTS_DBG_PROCESSED  8'h00
`define NTS_DBG_BAD_COOKIE 8'h02
`define NTS_DBG_BAD_AUTH   8'h04
`define NTS_DBG_BAD_KEYID  8'h06
`define NTS_DBG_NAME       8'h08
`define NTS_DBG_SYSTICK    8'h09
`define NTS_DBG_ERR_CRYPTO 8'h20
`define NTS_DBG_ERR_TXBUF  8'h22

`endif
